// File: source/hart_ctrl_pkg.sv
`default_nettype none

package hart_ctrl_pkg;

  // ------------------------------
  // vector geometry
  // ------------------------------

  // pending vector spans one hart register (xlen)
  localparam int unsigned IrqWidth = 64;

  // enough bits to name any vector position
  localparam int unsigned IrqIdWidth = 6;

  typedef logic [IrqWidth-1:0]   irq_vec_t;
  typedef logic [IrqIdWidth-1:0] irq_id_t;

  // ------------------------------
  // privileged spec positions
  // ------------------------------

  // machine software interrupt
  localparam int unsigned MsipBit = 3;
  // machine timer interrupt
  localparam int unsigned MtipBit = 7;
  // supervisor external interrupt
  localparam int unsigned SeipBit = 9;
  // machine external interrupt
  localparam int unsigned MeipBit = 11;

  // platform lines start here and run to the top of the vector
  localparam int unsigned PlatIrqBase = 16;
  localparam int unsigned NumPlatIrq  = 48;

  // ------------------------------
  // arbiter fsm
  // ------------------------------

  typedef enum logic [0:0] {
    ARB_IDLE = 1'b0,
    ARB_REQ  = 1'b1
  } arb_state_e;

endpackage

`default_nettype wire

// File: source/rst_sync.sv
`default_nettype none

module rst_sync (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic ndmreset_i,
  output logic rst_no
);

  // either power-on reset or a debug reset pulls the system down
  logic       rst_comb_n;
  logic [1:0] sync_q;

  assign rst_comb_n = rst_ni & ~ndmreset_i;

  // assert asynchronously, release after two clean edges
  always_ff @(posedge clk_i or negedge rst_comb_n) begin : p_sync
    if (!rst_comb_n) begin
      sync_q <= 2'b00;
    end else begin
      sync_q <= {sync_q[0], 1'b1};
    end
  end

  assign rst_no = sync_q[1];

endmodule

`default_nettype wire

// File: source/debug_holdoff.sv
`default_nettype none

module debug_holdoff #(
  parameter int unsigned HoldoffCycles = 500
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic debug_req_i,
  output logic debug_req_o
);

  // counter wide enough to hold the full window
  localparam int unsigned CntWidth =
    (HoldoffCycles > 0) ? $clog2(HoldoffCycles + 1) : 1;

  logic [CntWidth-1:0] cnt_d;
  logic [CntWidth-1:0] cnt_q;
  logic                cnt_zero;

  assign cnt_zero = (cnt_q == '0);

  // count down once per cycle and stop at zero
  assign cnt_d = cnt_zero ? cnt_q : cnt_q - 1'b1;

  // only power-on reset reloads the window
  // so a debug-triggered reset leaves it expired
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_cnt
    if (!rst_ni) begin
      cnt_q <= CntWidth'(HoldoffCycles);
    end else begin
      cnt_q <= cnt_d;
    end
  end

  // boot code runs undisturbed until the window closes
  assign debug_req_o = cnt_zero ? debug_req_i : 1'b0;

endmodule

`default_nettype wire

// File: source/irq_collect.sv
`default_nettype none

module irq_collect (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 meip_i,
  input  logic                                 seip_i,
  input  logic                                 mtip_i,
  input  logic                                 msip_i,
  input  logic [hart_ctrl_pkg::NumPlatIrq-1:0] plat_irq_i,
  input  hart_ctrl_pkg::irq_vec_t              irq_enable_i,
  output hart_ctrl_pkg::irq_vec_t              pending_o
);

  import hart_ctrl_pkg::*;

  irq_vec_t irq_raw;
  irq_vec_t irq_masked;
  irq_vec_t pending_q;

  // ------------------------------
  // spec numbering
  // ------------------------------

  // reserved positions stay zero
  always_comb begin : p_map
    irq_raw                              = '0;
    irq_raw[MsipBit]                     = msip_i;
    irq_raw[MtipBit]                     = mtip_i;
    irq_raw[SeipBit]                     = seip_i;
    irq_raw[MeipBit]                     = meip_i;
    irq_raw[PlatIrqBase +: NumPlatIrq]   = plat_irq_i;
  end

  // disabled sources never reach the arbiter
  assign irq_masked = irq_raw & irq_enable_i;

  // ------------------------------
  // pending register
  // ------------------------------

  // one cycle from sampled inputs to pending
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_pending
    if (!rst_ni) begin
      pending_q <= '0;
    end else begin
      pending_q <= irq_masked;
    end
  end

  assign pending_o = pending_q;

endmodule

`default_nettype wire

// File: source/irq_arbiter.sv
`default_nettype none

module irq_arbiter (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  hart_ctrl_pkg::irq_vec_t pending_i,
  input  logic                    irq_ack_i,
  output logic                    irq_valid_o,
  output hart_ctrl_pkg::irq_id_t  irq_id_o,
  output hart_ctrl_pkg::irq_vec_t irq_onehot_o
);

  import hart_ctrl_pkg::*;

  arb_state_e state_d;
  arb_state_e state_q;
  irq_id_t    id_d;
  irq_id_t    id_q;
  irq_id_t    top_id;
  logic       any_pending;

  // ------------------------------
  // priority pick
  // ------------------------------

  // later iterations win so the highest index is kept
  always_comb begin : p_prio
    top_id = '0;
    for (int unsigned i = 0; i < IrqWidth; i++) begin
      if (pending_i[i]) begin
        top_id = irq_id_t'(i);
      end
    end
  end

  assign any_pending = |pending_i;

  // ------------------------------
  // handshake fsm
  // ------------------------------

  always_comb begin : p_fsm
    state_d = state_q;
    id_d    = id_q;
    unique case (state_q)
      ARB_IDLE: begin
        if (any_pending) begin
          id_d    = top_id;
          state_d = ARB_REQ;
        end
      end
      ARB_REQ: begin
        // id held until the hart takes it, whatever the sources do
        if (irq_ack_i) begin
          state_d = ARB_IDLE;
        end
      end
      default: begin
        state_d = ARB_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      state_q <= ARB_IDLE;
      id_q    <= '0;
    end else begin
      state_q <= state_d;
      id_q    <= id_d;
    end
  end

  assign irq_valid_o = (state_q == ARB_REQ);
  assign irq_id_o    = id_q;

  // one-hot request the core expects, empty while idle
  always_comb begin : p_onehot
    irq_onehot_o = '0;
    if (state_q == ARB_REQ) begin
      irq_onehot_o[id_q] = 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: source/hart_ctrl_top.sv
`default_nettype none

module hart_ctrl_top #(
  parameter int unsigned HoldoffCycles = 500
) (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 ndmreset_i,
  input  logic                                 debug_req_i,
  input  logic                                 meip_i,
  input  logic                                 seip_i,
  input  logic                                 mtip_i,
  input  logic                                 msip_i,
  input  logic [hart_ctrl_pkg::NumPlatIrq-1:0] plat_irq_i,
  input  hart_ctrl_pkg::irq_vec_t              irq_enable_i,
  input  logic                                 irq_ack_i,
  output logic                                 sys_rst_no,
  output logic                                 debug_req_o,
  output logic                                 irq_valid_o,
  output hart_ctrl_pkg::irq_id_t               irq_id_o,
  output hart_ctrl_pkg::irq_vec_t              irq_onehot_o
);

  import hart_ctrl_pkg::*;

  // system reset for everything behind the synchronizer
  logic     sys_rst_n;
  irq_vec_t pending;

  // ------------------------------
  // reset and debug
  // ------------------------------

  rst_sync i_rst_sync (
    .clk_i      ( clk_i      ),
    .rst_ni     ( rst_ni     ),
    .ndmreset_i ( ndmreset_i ),
    .rst_no     ( sys_rst_n  )
  );

  assign sys_rst_no = sys_rst_n;

  // runs from power-on reset so ndmreset leaves it alone
  debug_holdoff #(
    .HoldoffCycles ( HoldoffCycles )
  ) i_debug_holdoff (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .debug_req_i ( debug_req_i ),
    .debug_req_o ( debug_req_o )
  );

  // ------------------------------
  // interrupts
  // ------------------------------

  irq_collect i_irq_collect (
    .clk_i        ( clk_i        ),
    .rst_ni       ( sys_rst_n    ),
    .meip_i       ( meip_i       ),
    .seip_i       ( seip_i       ),
    .mtip_i       ( mtip_i       ),
    .msip_i       ( msip_i       ),
    .plat_irq_i   ( plat_irq_i   ),
    .irq_enable_i ( irq_enable_i ),
    .pending_o    ( pending      )
  );

  irq_arbiter i_irq_arbiter (
    .clk_i        ( clk_i        ),
    .rst_ni       ( sys_rst_n    ),
    .pending_i    ( pending      ),
    .irq_ack_i    ( irq_ack_i    ),
    .irq_valid_o  ( irq_valid_o  ),
    .irq_id_o     ( irq_id_o     ),
    .irq_onehot_o ( irq_onehot_o )
  );

endmodule

`default_nettype wire

// File: verification/hart_ctrl_asserts.sv
`default_nettype none

module hart_ctrl_asserts #(
  parameter int unsigned HoldoffCycles = 500
) (
  input logic                                 clk_i,
  input logic                                 rst_ni,
  input logic                                 ndmreset_i,
  input logic                                 debug_req_i,
  input logic                                 meip_i,
  input logic                                 seip_i,
  input logic                                 mtip_i,
  input logic                                 msip_i,
  input logic [hart_ctrl_pkg::NumPlatIrq-1:0] plat_irq_i,
  input hart_ctrl_pkg::irq_vec_t              irq_enable_i,
  input logic                                 irq_ack_i,
  input logic                                 sys_rst_ni,
  input logic                                 debug_out_i,
  input logic                                 irq_valid_i,
  input hart_ctrl_pkg::irq_id_t               irq_id_i,
  input hart_ctrl_pkg::irq_vec_t              irq_onehot_i
);

  import hart_ctrl_pkg::*;

  irq_vec_t    model_raw;
  irq_vec_t    model_pending_q;
  irq_id_t     model_top_q;
  logic        model_any_q;
  int unsigned boot_cnt_q;
  logic        rel;
  logic        failed = 1'b0;

  function automatic irq_id_t highest_set(irq_vec_t v);
    irq_id_t idx;
    logic    found;
    idx   = '0;
    found = 1'b0;
    for (int i = IrqWidth - 1; i >= 0; i--) begin
      if (v[i] && !found) begin
        idx   = irq_id_t'(i);
        found = 1'b1;
      end
    end
    return idx;
  endfunction

  // ------------------------------
  // reference model
  // ------------------------------

  assign rel = rst_ni && !ndmreset_i;

  always_comb begin : p_model_map
    model_raw                            = '0;
    model_raw[MsipBit]                   = msip_i;
    model_raw[MtipBit]                   = mtip_i;
    model_raw[SeipBit]                   = seip_i;
    model_raw[MeipBit]                   = meip_i;
    model_raw[PlatIrqBase +: NumPlatIrq] = plat_irq_i;
  end

  // pending one edge behind the inputs, expected pick one more behind
  always_ff @(posedge clk_i or negedge sys_rst_ni) begin : p_model
    if (!sys_rst_ni) begin
      model_pending_q <= '0;
      model_top_q     <= '0;
      model_any_q     <= 1'b0;
    end else begin
      model_pending_q <= model_raw & irq_enable_i;
      model_top_q     <= highest_set(model_pending_q);
      model_any_q     <= |model_pending_q;
    end
  end

  // edges seen since power-on reset released
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_boot
    if (!rst_ni) begin
      boot_cnt_q <= 0;
    end else if (boot_cnt_q < HoldoffCycles) begin
      boot_cnt_q <= boot_cnt_q + 1;
    end
  end

  // ------------------------------
  // reset
  // ------------------------------

  a_rst_assert: assert property (@(posedge clk_i) !rel |-> !sys_rst_ni)
    else begin
      $error("system reset high while a reset source is active");
      failed = 1'b1;
    end

  a_rst_release: assert property (@(posedge clk_i) (rel ##1 rel ##1 rel) |-> sys_rst_ni)
    else begin
      $error("system reset still low two edges after release");
      failed = 1'b1;
    end

  a_rst_early: assert property (@(posedge clk_i)
    $rose(sys_rst_ni) |-> ($past(rel) && $past(rel, 2)))
    else begin
      $error("system reset released too early");
      failed = 1'b1;
    end

  a_valid_in_reset: assert property (@(posedge clk_i) !sys_rst_ni |-> !irq_valid_i)
    else begin
      $error("interrupt request valid during system reset");
      failed = 1'b1;
    end

  // ------------------------------
  // debug and interrupts
  // ------------------------------

  a_holdoff: assert property (@(posedge clk_i) disable iff (!rst_ni)
    debug_out_i == (debug_req_i && (boot_cnt_q == HoldoffCycles)))
    else begin
      $error("ERROR debug_req_o = %h, expected %h", $sampled(debug_out_i),
             $sampled(debug_req_i && (boot_cnt_q == HoldoffCycles)));
      failed = 1'b1;
    end

  a_onehot: assert property (@(posedge clk_i)
    irq_onehot_i == (irq_valid_i ? (irq_vec_t'(1) << irq_id_i) : irq_vec_t'(0)))
    else begin
      $error("ERROR irq_onehot_o = %h, irq_id_o = %h", $sampled(irq_onehot_i),
             $sampled(irq_id_i));
      failed = 1'b1;
    end

  a_hold: assert property (@(posedge clk_i) disable iff (!sys_rst_ni)
    (irq_valid_i && !irq_ack_i) |=> (irq_valid_i && $stable(irq_id_i)))
    else begin
      $error("request dropped or changed while the acknowledge was withheld");
      failed = 1'b1;
    end

  a_ack_gap: assert property (@(posedge clk_i) disable iff (!sys_rst_ni)
    (irq_valid_i && irq_ack_i) |=> !irq_valid_i)
    else begin
      $error("request still valid right after an acknowledge");
      failed = 1'b1;
    end

  a_request: assert property (@(posedge clk_i) disable iff (!sys_rst_ni)
    (!irq_valid_i && |model_pending_q) |=> irq_valid_i)
    else begin
      $error("idle arbiter did not raise a request for a pending interrupt");
      failed = 1'b1;
    end

  a_no_spurious: assert property (@(posedge clk_i) disable iff (!sys_rst_ni)
    $rose(irq_valid_i) |-> model_any_q)
    else begin
      $error("request raised with no enabled interrupt pending");
      failed = 1'b1;
    end

  a_id: assert property (@(posedge clk_i) disable iff (!sys_rst_ni)
    $rose(irq_valid_i) |-> (irq_id_i == model_top_q))
    else begin
      $error("ERROR irq_id_o = %h, expected %h", $sampled(irq_id_i), $sampled(model_top_q));
      failed = 1'b1;
    end

endmodule

bind hart_ctrl_top hart_ctrl_asserts #(
  .HoldoffCycles ( HoldoffCycles )
) i_asserts (
  .clk_i        ( clk_i        ),
  .rst_ni       ( rst_ni       ),
  .ndmreset_i   ( ndmreset_i   ),
  .debug_req_i  ( debug_req_i  ),
  .meip_i       ( meip_i       ),
  .seip_i       ( seip_i       ),
  .mtip_i       ( mtip_i       ),
  .msip_i       ( msip_i       ),
  .plat_irq_i   ( plat_irq_i   ),
  .irq_enable_i ( irq_enable_i ),
  .irq_ack_i    ( irq_ack_i    ),
  .sys_rst_ni   ( sys_rst_no   ),
  .debug_out_i  ( debug_req_o  ),
  .irq_valid_i  ( irq_valid_o  ),
  .irq_id_i     ( irq_id_o     ),
  .irq_onehot_i ( irq_onehot_o )
);

`default_nettype wire

// File: verification/hart_ctrl_tb.sv
`default_nettype none

module hart_ctrl_tb;

  import hart_ctrl_pkg::*;

  localparam int unsigned HoldoffCycles  = 20;
  localparam int unsigned ClkHalf        = 20;
  localparam int unsigned RandomCycles   = 300;
  localparam int unsigned WatchdogCycles = 2000;
  localparam int unsigned WaitLimit      = 50;
  localparam logic [31:0] Seed           = 32'h8f0b_e743;

  logic                  clk_i;
  logic                  rst_ni;
  logic                  ndmreset_i;
  logic                  debug_req_i;
  logic                  meip_i;
  logic                  seip_i;
  logic                  mtip_i;
  logic                  msip_i;
  logic [NumPlatIrq-1:0] plat_irq_i;
  irq_vec_t              irq_enable_i;
  logic                  irq_ack_i;
  logic                  sys_rst_no;
  logic                  debug_req_o;
  logic                  irq_valid_o;
  irq_id_t               irq_id_o;
  irq_vec_t              irq_onehot_o;

  hart_ctrl_top #(
    .HoldoffCycles ( HoldoffCycles )
  ) uut (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .ndmreset_i   ( ndmreset_i   ),
    .debug_req_i  ( debug_req_i  ),
    .meip_i       ( meip_i       ),
    .seip_i       ( seip_i       ),
    .mtip_i       ( mtip_i       ),
    .msip_i       ( msip_i       ),
    .plat_irq_i   ( plat_irq_i   ),
    .irq_enable_i ( irq_enable_i ),
    .irq_ack_i    ( irq_ack_i    ),
    .sys_rst_no   ( sys_rst_no   ),
    .debug_req_o  ( debug_req_o  ),
    .irq_valid_o  ( irq_valid_o  ),
    .irq_id_o     ( irq_id_o     ),
    .irq_onehot_o ( irq_onehot_o )
  );

  always #ClkHalf clk_i = ~clk_i;

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("Verification failed");
    $fatal(1, "run stopped");
  endtask

  // places a raw vector onto the individual source lines
  task automatic drive_sources(input irq_vec_t v);
    msip_i     = v[MsipBit];
    mtip_i     = v[MtipBit];
    seip_i     = v[SeipBit];
    meip_i     = v[MeipBit];
    plat_irq_i = v[PlatIrqBase +: NumPlatIrq];
  endtask

  task automatic wait_for_request(input string what);
    int unsigned n;
    n = 0;
    while (!irq_valid_o && n < WaitLimit) begin
      @(negedge clk_i);
      n++;
    end
    if (!irq_valid_o) begin
      stop_with_failure({"no interrupt request arrived for ", what});
    end
  endtask

  task automatic take_request();
    irq_ack_i = 1'b1;
    @(negedge clk_i);
    irq_ack_i = 1'b0;
  endtask

  task automatic drain_requests();
    drive_sources('0);
    repeat (4) begin
      @(negedge clk_i);
      if (irq_valid_o) begin
        take_request();
      end
    end
  endtask

  task automatic map_single(input irq_vec_t v, input string what);
    drive_sources(v);
    wait_for_request(what);
    repeat (2) @(negedge clk_i);
    drive_sources('0);
    take_request();
    @(negedge clk_i);
  endtask

  // ------------------------------
  // failure watch and watchdog
  // ------------------------------

  always @(negedge clk_i) begin
    if (uut.i_asserts.failed) begin
      stop_with_failure("an assertion failed");
    end
  end

  initial begin
    #(WatchdogCycles * 2 * ClkHalf);
    stop_with_failure("watchdog expired before the tests finished");
  end

  // ------------------------------
  // stimulus
  // ------------------------------

  initial begin
    irq_vec_t v;
    void'($urandom(Seed));
    clk_i        = 1'b0;
    rst_ni       = 1'b0;
    ndmreset_i   = 1'b0;
    debug_req_i  = 1'b1;
    drive_sources('0);
    irq_enable_i = '1;
    irq_ack_i    = 1'b0;
    repeat (2) @(negedge clk_i);
    rst_ni = 1'b1;

    // hold-off window, then ndmreset must not reopen it
    repeat (HoldoffCycles + 4) @(negedge clk_i);
    // debug reset lands while a request waits for the hart
    drive_sources(irq_vec_t'(1) << MeipBit);
    wait_for_request("meip before debug reset");
    ndmreset_i = 1'b1;
    drive_sources('0);
    @(negedge clk_i);
    ndmreset_i = 1'b0;
    repeat (4) @(negedge clk_i);
    debug_req_i = 1'b0;
    @(negedge clk_i);
    debug_req_i = 1'b1;
    @(negedge clk_i);

    map_single(irq_vec_t'(1) << MsipBit, "msip");
    map_single(irq_vec_t'(1) << MtipBit, "mtip");
    map_single(irq_vec_t'(1) << SeipBit, "seip");
    map_single(irq_vec_t'(1) << MeipBit, "meip");
    map_single(irq_vec_t'(1) << (PlatIrqBase + 5), "platform line 5");

    // masked source stays quiet until enabled
    irq_enable_i[MtipBit] = 1'b0;
    drive_sources(irq_vec_t'(1) << MtipBit);
    repeat (8) @(negedge clk_i);
    irq_enable_i[MtipBit] = 1'b1;
    wait_for_request("mtip after enable");
    drive_sources('0);
    take_request();
    @(negedge clk_i);

    // several pending, hart stalls while sources change
    v = '0;
    v[MsipBit] = 1'b1;
    v[MtipBit] = 1'b1;
    v[MeipBit] = 1'b1;
    v[PlatIrqBase + 3] = 1'b1;
    drive_sources(v);
    wait_for_request("several sources");
    v[PlatIrqBase + 3] = 1'b0;
    v[PlatIrqBase + 40] = 1'b1;
    drive_sources(v);
    repeat (5) @(negedge clk_i);
    repeat (3) begin
      take_request();
      wait_for_request("next highest source");
    end
    drain_requests();

    // sparse random sources, enables and acknowledges
    for (int unsigned c = 0; c < RandomCycles; c++) begin
      v = {$urandom, $urandom} & {$urandom, $urandom} & {$urandom, $urandom};
      drive_sources(v);
      irq_enable_i = {$urandom, $urandom};
      irq_ack_i    = (($urandom % 3) == 0);
      @(negedge clk_i);
    end
    irq_ack_i = 1'b0;
    drain_requests();

    if (uut.i_asserts.failed) begin
      stop_with_failure("an assertion failed");
    end else begin
      $display("Verification passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: project.f
source/hart_ctrl_pkg.sv
source/rst_sync.sv
source/debug_holdoff.sv
source/irq_collect.sv
source/irq_arbiter.sv
source/hart_ctrl_top.sv
verification/hart_ctrl_asserts.sv
verification/hart_ctrl_tb.sv

// File: Bender.yml
package:
  name: hart_ctrl

sources:
  - source/hart_ctrl_pkg.sv
  - source/rst_sync.sv
  - source/debug_holdoff.sv
  - source/irq_collect.sv
  - source/irq_arbiter.sv
  - source/hart_ctrl_top.sv
  - target: test
    files:
      - verification/hart_ctrl_asserts.sv
      - verification/hart_ctrl_tb.sv
